//--- src/tpu_types_pkg.sv
package tpu_types_pkg;

  // Element and product-sum widths
  localparam int DATA_W = 16;
  localparam int ACC_W = 32;

  // Unified buffer geometry
  localparam int UB_DEPTH = 64;
  localparam int UB_ADDR_W = $clog2(UB_DEPTH);

  // Weight ROM holds four 2x2 tiles
  localparam int WMEM_WORDS = 16;
  localparam int TILE_SEL_W = $clog2(WMEM_WORDS / 4);

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [ACC_W-1:0] acc_t;
  typedef logic [UB_ADDR_W-1:0] ub_addr_t;
  typedef logic [TILE_SEL_W-1:0] tile_sel_t;

  // Row-major weight tile, w11 in the top bits
  typedef struct packed {
    data_t w11;
    data_t w12;
    data_t w21;
    data_t w22;
  } weight_tile_t;

  // Row-major activation tile
  typedef struct packed {
    data_t a11;
    data_t a12;
    data_t a21;
    data_t a22;
  } act_tile_t;

  // Bottom of one array column
  typedef struct packed {
    logic valid;
    acc_t sum;
  } col_out_t;

  // Both results of one column, top row in r0
  typedef struct packed {
    acc_t r0;
    acc_t r1;
  } col_pair_t;

endpackage

//--- src/tpu_isa_pkg.sv
package tpu_isa_pkg;

  // Instruction word layout
  localparam int INSTR_W = 16;
  localparam int OP_W = 3;
  localparam int ADDR_FIELD_W = INSTR_W - OP_W;

  typedef enum logic [OP_W-1:0] {
    NOP         = 3'd0,
    WRITE_UB    = 3'd1,
    LOAD_WEIGHT = 3'd2,
    MATMUL      = 3'd3,
    MATMUL_ACC  = 3'd4,
    READ_UB     = 3'd5
  } opcode_e;

  // Opcode in the top three bits
  // Address field doubles as buffer address or tile number
  typedef struct packed {
    opcode_e                 op;
    logic [ADDR_FIELD_W-1:0] addr;
  } instr_t;

endpackage

//--- src/control_unit.sv
module control_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      instr_req,
  input  tpu_isa_pkg::instr_t       instr,
  output logic                      instr_ack,
  output tpu_types_pkg::ub_addr_t   ub_addr,
  output tpu_types_pkg::tile_sel_t  tile_sel,
  output logic                      ub_we,
  output logic                      ub_rd,
  output logic                      act_fetch,
  output logic                      stream_start,
  output logic                      acc_mode,
  output logic                      weight_load,
  input  logic                      tile_stored
);
  import tpu_isa_pkg::*;
  import tpu_types_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    EXEC,
    FETCH,
    STREAM,
    WAIT_STORE,
    ACK,
    RELEASE
  } ctrl_state_e;

  ctrl_state_e state;
  instr_t      instr_q;
  logic        is_matmul;

  // Both matrix ops share the fetch and stream path
  assign is_matmul = (instr.op == MATMUL) || (instr.op == MATMUL_ACC);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          // Capture the instruction while req holds it stable
          if (instr_req) begin
            instr_q <= instr;
            state   <= is_matmul ? FETCH : EXEC;
          end
        end
        EXEC:       state <= ACK;
        FETCH:      state <= STREAM;
        STREAM:     state <= WAIT_STORE;
        // Pipeline drains through both accumulators into the buffer
        WAIT_STORE: if (tile_stored) state <= ACK;
        // Keep ack up until the host drops req
        ACK:        if (!instr_req) state <= RELEASE;
        RELEASE:    state <= IDLE;
        default:    state <= IDLE;
      endcase
    end
  end

  assign instr_ack = (state == ACK);

  // Single-cycle strobes, one per step
  assign ub_we        = (state == EXEC) && (instr_q.op == WRITE_UB);
  assign ub_rd        = (state == EXEC) && (instr_q.op == READ_UB);
  assign weight_load  = (state == EXEC) && (instr_q.op == LOAD_WEIGHT);
  assign act_fetch    = (state == FETCH);
  assign stream_start = (state == STREAM);

  // Level signals taken from the held instruction
  assign acc_mode = (instr_q.op == MATMUL_ACC);
  // Upper address bits are ignored, so addresses wrap
  assign ub_addr  = ub_addr_t'(instr_q.addr);
  assign tile_sel = tile_sel_t'(instr_q.addr);

endmodule

//--- src/weight_memory.sv
module weight_memory (
  input  tpu_types_pkg::tile_sel_t    tile_sel,
  output tpu_types_pkg::weight_tile_t tile
);
  import tpu_types_pkg::*;

  // Four words per tile, in w11 w12 w21 w22 order
  data_t rom [WMEM_WORDS];

  initial begin
    $readmemh("src/weights.mem", rom);
  end

  // Tile number forms the upper index bits
  always_comb begin
    tile.w11 = rom[{tile_sel, 2'd0}];
    tile.w12 = rom[{tile_sel, 2'd1}];
    tile.w21 = rom[{tile_sel, 2'd2}];
    tile.w22 = rom[{tile_sel, 2'd3}];
  end

endmodule

//--- src/input_setup.sv
module input_setup (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stream_start,
  input  tpu_types_pkg::act_tile_t  act,
  output tpu_types_pkg::data_t      a_in1,
  output logic                      a_vld1,
  output tpu_types_pkg::data_t      a_in2,
  output logic                      a_vld2
);
  import tpu_types_pkg::*;

  act_tile_t  tile_q;
  logic [1:0] step;

  always_ff @(posedge clk) begin
    if (stream_start) tile_q <= act;
  end

  // Step 0 is idle, steps 1 to 3 are the wavefronts
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step <= 2'd0;
    end else if (stream_start) begin
      step <= 2'd1;
    end else if (step == 2'd3) begin
      step <= 2'd0;
    end else if (step != 2'd0) begin
      step <= step + 2'd1;
    end
  end

  // Row 2 trails row 1 by one cycle
  always_comb begin
    a_in1  = '0;
    a_in2  = '0;
    a_vld1 = 1'b0;
    a_vld2 = 1'b0;
    case (step)
      2'd1: begin
        a_in1  = tile_q.a11;
        a_vld1 = 1'b1;
      end
      2'd2: begin
        a_in1  = tile_q.a21;
        a_vld1 = 1'b1;
        a_in2  = tile_q.a12;
        a_vld2 = 1'b1;
      end
      2'd3: begin
        a_in2  = tile_q.a22;
        a_vld2 = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- src/mmu.sv
module mmu (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         weight_load,
  input  tpu_types_pkg::weight_tile_t  weights,
  input  tpu_types_pkg::data_t         a_in1,
  input  logic                         a_vld1,
  input  tpu_types_pkg::data_t         a_in2,
  input  logic                         a_vld2,
  output tpu_types_pkg::col_out_t      col1,
  output tpu_types_pkg::col_out_t      col2
);
  import tpu_types_pkg::*;

  // Everything below is indexed [row][col]
  data_t row_a [2];
  logic  row_v [2];
  data_t w_in  [2][2];

  // Stationary weights and registered partial sums
  data_t w_q  [2][2];
  acc_t  p_q  [2][2];
  logic  pv_q [2][2];
  // Activation passed from column 0 to column 1
  data_t a_q  [2];
  logic  av_q [2];

  assign row_a[0]   = a_in1;
  assign row_a[1]   = a_in2;
  assign row_v[0]   = a_vld1;
  assign row_v[1]   = a_vld2;
  assign w_in[0][0] = weights.w11;
  assign w_in[0][1] = weights.w12;
  assign w_in[1][0] = weights.w21;
  assign w_in[1][1] = weights.w22;

  for (genvar r = 0; r < 2; r++) begin : g_row
    for (genvar c = 0; c < 2; c++) begin : g_col
      data_t a_src;
      logic  av_src;
      acc_t  p_src;
      logic  pv_src;

      // West edge cells take the skewed row input
      if (c == 0) begin : g_west
        assign a_src  = row_a[r];
        assign av_src = row_v[r];
        always_ff @(posedge clk) begin
          a_q[r] <= a_src;
        end
        always_ff @(posedge clk) begin
          if (!rst_n) av_q[r] <= 1'b0;
          else        av_q[r] <= av_src;
        end
      end else begin : g_east
        assign a_src  = a_q[r];
        assign av_src = av_q[r];
      end

      // Top row starts every sum from zero
      if (r == 0) begin : g_top
        assign p_src  = '0;
        assign pv_src = 1'b1;
      end else begin : g_bottom
        assign p_src  = p_q[r-1][c];
        assign pv_src = pv_q[r-1][c];
      end

      always_ff @(posedge clk) begin
        if (weight_load) w_q[r][c] <= w_in[r][c];
        p_q[r][c] <= p_src + acc_t'(a_src) * acc_t'(w_q[r][c]);
      end

      // Sum is complete only when every term it holds was valid
      always_ff @(posedge clk) begin
        if (!rst_n) pv_q[r][c] <= 1'b0;
        else        pv_q[r][c] <= av_src & pv_src;
      end
    end
  end

  assign col1.valid = pv_q[1][0];
  assign col1.sum   = p_q[1][0];
  assign col2.valid = pv_q[1][1];
  assign col2.sum   = p_q[1][1];

endmodule

//--- src/accumulator.sv
module accumulator (
  input  logic                      clk,
  input  logic                      rst_n,
  input  tpu_types_pkg::col_out_t   col,
  input  logic                      start,
  input  logic                      acc_mode,
  output tpu_types_pkg::col_pair_t  results,
  output logic                      done
);

  logic armed;
  logic second;
  logic add_mode;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      armed    <= 1'b0;
      second   <= 1'b0;
      add_mode <= 1'b0;
      done     <= 1'b0;
      results  <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        // Mode is fixed for the whole tile
        armed    <= 1'b1;
        second   <= 1'b0;
        add_mode <= acc_mode;
      end else if (armed && col.valid) begin
        if (!second) begin
          // Top-row result
          results.r0 <= add_mode ? results.r0 + col.sum : col.sum;
          second     <= 1'b1;
        end else begin
          results.r1 <= add_mode ? results.r1 + col.sum : col.sum;
          armed      <= 1'b0;
          done       <= 1'b1;
        end
      end
    end
  end

endmodule

//--- src/unified_buffer.sv
module unified_buffer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  tpu_types_pkg::ub_addr_t   addr,
  input  logic                      ub_we,
  input  tpu_types_pkg::data_t      wdata,
  input  logic                      ub_rd,
  output tpu_types_pkg::acc_t       rd_data,
  input  logic                      act_fetch,
  output tpu_types_pkg::act_tile_t  act,
  input  logic                      done1,
  input  logic                      done2,
  input  tpu_types_pkg::col_pair_t  col1_res,
  input  tpu_types_pkg::col_pair_t  col2_res,
  output logic                      tile_stored
);
  import tpu_types_pkg::*;

  acc_t mem [UB_DEPTH];
  logic seen1;
  logic seen2;
  logic store_now;

  // Offset from the base, wrapping at the buffer size
  function automatic ub_addr_t offs(ub_addr_t base, int unsigned k);
    return base + ub_addr_t'(k);
  endfunction

  // Column 2 finishes a cycle after column 1
  assign store_now = (seen1 | done1) & (seen2 | done2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < UB_DEPTH; i++) mem[i] <= '0;
      seen1       <= 1'b0;
      seen2       <= 1'b0;
      tile_stored <= 1'b0;
      rd_data     <= '0;
    end else begin
      tile_stored <= 1'b0;
      if (store_now) begin
        // Result tile goes right after the operand tile
        mem[offs(addr, 4)] <= col1_res.r0;
        mem[offs(addr, 5)] <= col2_res.r0;
        mem[offs(addr, 6)] <= col1_res.r1;
        mem[offs(addr, 7)] <= col2_res.r1;
        seen1       <= 1'b0;
        seen2       <= 1'b0;
        tile_stored <= 1'b1;
      end else begin
        if (done1) seen1 <= 1'b1;
        if (done2) seen2 <= 1'b1;
      end
      // Host words are stored sign-extended
      if (ub_we) mem[addr] <= acc_t'(wdata);
      if (ub_rd) rd_data <= mem[addr];
    end
  end

  // Operand tile, low half of each word
  always_ff @(posedge clk) begin
    if (act_fetch) begin
      act.a11 <= data_t'(mem[offs(addr, 0)]);
      act.a12 <= data_t'(mem[offs(addr, 1)]);
      act.a21 <= data_t'(mem[offs(addr, 2)]);
      act.a22 <= data_t'(mem[offs(addr, 3)]);
    end
  end

endmodule

//--- src/tpu_core.sv
module tpu_core (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_req,
  input  tpu_isa_pkg::instr_t   instr,
  input  tpu_types_pkg::data_t  wdata,
  output logic                  instr_ack,
  output tpu_types_pkg::acc_t   rd_data
);
  import tpu_types_pkg::*;

  // Sequencer controls
  ub_addr_t  ub_addr;
  tile_sel_t tile_sel;
  logic      ub_we;
  logic      ub_rd;
  logic      act_fetch;
  logic      stream_start;
  logic      acc_mode;
  logic      weight_load;
  logic      tile_stored;

  // Datapath
  weight_tile_t wtile;
  act_tile_t    act;
  data_t        a_in1;
  data_t        a_in2;
  logic         a_vld1;
  logic         a_vld2;
  col_out_t     col1;
  col_out_t     col2;
  col_pair_t    res1;
  col_pair_t    res2;
  logic         done1;
  logic         done2;

  control_unit cu (
    .clk(clk), .rst_n(rst_n), .instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
    .ub_addr(ub_addr), .tile_sel(tile_sel), .ub_we(ub_we), .ub_rd(ub_rd),
    .act_fetch(act_fetch), .stream_start(stream_start), .acc_mode(acc_mode),
    .weight_load(weight_load), .tile_stored(tile_stored)
  );

  weight_memory wm (.tile_sel(tile_sel), .tile(wtile));

  // Row valids travel with the skewed activations
  input_setup is_stage (
    .clk(clk), .rst_n(rst_n), .stream_start(stream_start), .act(act),
    .a_in1(a_in1), .a_vld1(a_vld1), .a_in2(a_in2), .a_vld2(a_vld2)
  );

  mmu systolic_array (
    .clk(clk), .rst_n(rst_n), .weight_load(weight_load), .weights(wtile),
    .a_in1(a_in1), .a_vld1(a_vld1), .a_in2(a_in2), .a_vld2(a_vld2),
    .col1(col1), .col2(col2)
  );

  // One accumulator per array column
  accumulator acc1 (
    .clk(clk), .rst_n(rst_n), .col(col1), .start(stream_start),
    .acc_mode(acc_mode), .results(res1), .done(done1)
  );

  accumulator acc2 (
    .clk(clk), .rst_n(rst_n), .col(col2), .start(stream_start),
    .acc_mode(acc_mode), .results(res2), .done(done2)
  );

  unified_buffer ub (
    .clk(clk), .rst_n(rst_n), .addr(ub_addr), .ub_we(ub_we), .wdata(wdata),
    .ub_rd(ub_rd), .rd_data(rd_data), .act_fetch(act_fetch), .act(act),
    .done1(done1), .done2(done2), .col1_res(res1), .col2_res(res2),
    .tile_stored(tile_stored)
  );

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk
);

  // Free-running clock, 40 units per period
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

endmodule

//--- sim/tpu_core_tb.sv
module tpu_core_tb;
  import tpu_types_pkg::*;
  import tpu_isa_pkg::*;

  // One row of the stimulus table
  typedef struct packed {
    opcode_e     op;
    logic [12:0] addr;
    data_t       wdata;
    logic        check;
    acc_t        expected;
  } entry_t;

  logic   clk;
  logic   rst_n;
  logic   instr_req;
  instr_t instr;
  data_t  wdata;
  logic   instr_ack;
  acc_t   rd_data;

  // Reference model state
  logic [15:0]  wmem [WMEM_WORDS];
  acc_t         ub_model [UB_DEPTH];
  acc_t         acc_model [4];
  weight_tile_t w_model;
  entry_t       table_q [$];

  logic [31:0] lfsr = 32'd83292;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic        ack_prev;
  acc_t        rd_prev;

  tb_clock_gen clk_gen (.clk(clk));

  tpu_core uut (
    .clk(clk), .rst_n(rst_n), .instr_req(instr_req), .instr(instr),
    .wdata(wdata), .instr_ack(instr_ack), .rd_data(rd_data)
  );

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Checks failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One register step per bit taken
  function automatic data_t random_act(input bit force_neg);
    data_t v;
    for (int i = 0; i < 16; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    if (force_neg) v[15] = 1'b1;
    return v;
  endfunction

  task automatic store_word(input int addr, input data_t d);
    ub_model[ub_addr_t'(addr)] = acc_t'(d);
    table_q.push_back('{op: WRITE_UB, addr: 13'(addr), wdata: d, check: 1'b0, expected: '0});
  endtask

  task automatic read_word(input int addr);
    table_q.push_back('{op: READ_UB, addr: 13'(addr), wdata: '0, check: 1'b1,
                        expected: ub_model[ub_addr_t'(addr)]});
  endtask

  task automatic pick_tile(input int t);
    w_model.w11 = data_t'(wmem[4*t]);
    w_model.w12 = data_t'(wmem[4*t+1]);
    w_model.w21 = data_t'(wmem[4*t+2]);
    w_model.w22 = data_t'(wmem[4*t+3]);
    table_q.push_back('{op: LOAD_WEIGHT, addr: 13'(t), wdata: '0, check: 1'b0, expected: '0});
  endtask

  // C[i][j] = A[i][1]W[1][j] + A[i][2]W[2][j], results at addr+4 onward
  task automatic multiply_tile(input int addr, input bit accumulate);
    act_tile_t a;
    acc_t      c [4];
    a.a11 = data_t'(ub_model[ub_addr_t'(addr)]);
    a.a12 = data_t'(ub_model[ub_addr_t'(addr + 1)]);
    a.a21 = data_t'(ub_model[ub_addr_t'(addr + 2)]);
    a.a22 = data_t'(ub_model[ub_addr_t'(addr + 3)]);
    c[0] = acc_t'(a.a11) * acc_t'(w_model.w11) + acc_t'(a.a12) * acc_t'(w_model.w21);
    c[1] = acc_t'(a.a11) * acc_t'(w_model.w12) + acc_t'(a.a12) * acc_t'(w_model.w22);
    c[2] = acc_t'(a.a21) * acc_t'(w_model.w11) + acc_t'(a.a22) * acc_t'(w_model.w21);
    c[3] = acc_t'(a.a21) * acc_t'(w_model.w12) + acc_t'(a.a22) * acc_t'(w_model.w22);
    for (int k = 0; k < 4; k++) begin
      acc_model[k] = accumulate ? acc_model[k] + c[k] : c[k];
      ub_model[ub_addr_t'(addr + 4 + k)] = acc_model[k];
    end
    table_q.push_back('{op: accumulate ? MATMUL_ACC : MATMUL, addr: 13'(addr), wdata: '0,
                        check: 1'b0, expected: '0});
  endtask

  // Full four-phase transfer of one table row
  task automatic run_entry(input entry_t e);
    @(posedge clk);
    #2;
    instr     = '{op: e.op, addr: e.addr};
    wdata     = e.wdata;
    instr_req = 1'b1;
    do @(negedge clk); while (!instr_ack);
    if (e.check) check_value(rd_data, e.expected, $sformatf("rd_data of READ_UB %0d", e.addr));
    @(posedge clk);
    #2;
    instr_req = 1'b0;
    do @(negedge clk); while (instr_ack);
  endtask

  // Handshake order, sampled away from the active edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (instr_ack && !ack_prev) check_value(32'(instr_req), 32'd1, "req when ack rose");
      if (!instr_ack && ack_prev) check_value(32'(instr_req), 32'd0, "req when ack fell");
      if (instr_ack && ack_prev) check_value(rd_data, rd_prev, "rd_data while ack high");
    end
    ack_prev = instr_ack;
    rd_prev  = rd_data;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("Checks failed");
      $fatal(1, "run stopped by timeout");
    end
  end

  initial begin
    rst_n     = 1'b0;
    instr_req = 1'b0;
    instr     = '0;
    wdata     = '0;
    $readmemh("src/weights.mem", wmem);
    for (int i = 0; i < UB_DEPTH; i++) ub_model[i] = '0;
    for (int k = 0; k < 4; k++) acc_model[k] = '0;

    // Buffer is clear after reset
    read_word(0);
    read_word(17);
    read_word(63);
    // Sign extension and wrapped host addresses
    store_word(5, 16'h1234);
    store_word(70, 16'hF00D);
    store_word(127, 16'h8001);
    store_word(4100, 16'h7FFF);
    read_word(5);
    read_word(6);
    read_word(63);
    read_word(69);
    read_word(4);
    // Every weight tile on fresh activations
    for (int t = 0; t < 4; t++) begin
      for (int k = 0; k < 4; k++) store_word(8 + 8*t + k, random_act(k == t));
      pick_tile(t);
      multiply_tile(8 + 8*t, 1'b0);
      for (int k = 4; k < 8; k++) read_word(8 + 8*t + k);
    end
    // Accumulate onto the tile 3 products
    for (int k = 0; k < 4; k++) store_word(48 + k, random_act(k[0]));
    multiply_tile(48, 1'b1);
    for (int k = 4; k < 8; k++) read_word(48 + k);
    // Largest magnitudes, so sums pass 2^31
    for (int k = 0; k < 4; k++) store_word(40 + k, 16'h8000);
    pick_tile(2);
    multiply_tile(40, 1'b0);
    multiply_tile(40, 1'b1);
    for (int k = 4; k < 8; k++) read_word(40 + k);
    // Operands wrap from 62 round to 1 and results land at 2 to 5
    for (int k = 0; k < 4; k++) store_word(62 + k, random_act(k == 2));
    pick_tile(1);
    multiply_tile(62, 1'b0);
    for (int k = 4; k < 8; k++) read_word(62 + k);
    cycle_limit = 40 * table_q.size();

    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value(32'(instr_ack), 32'd0, "instr_ack after reset");

    foreach (table_q[i]) run_entry(table_q[i]);

    $display("All checks passed");
    $finish;
  end

endmodule

//--- src/weights.mem
// One signed 16-bit weight per line, four lines per tile in w11 w12 w21 w22 order
0001
0002
0003
0004
FFFF
0005
0007
FFFE
7FFF
8000
0123
FEDC
8000
7FFF
8000
8001

//--- src.f
src/tpu_types_pkg.sv
src/tpu_isa_pkg.sv
src/control_unit.sv
src/weight_memory.sv
src/input_setup.sv
src/mmu.sv
src/accumulator.sv
src/unified_buffer.sv
src/tpu_core.sv
sim/tb_clock_gen.sv
sim/tpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the simulation, run it, then look for the pass line in its output
verilator --binary --timing -f src.f --top-module tpu_core_tb -o tpu_sim || exit 1
out=$(./obj_dir/tpu_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
